// ==== bench/tb_hps_model.sv ====
`timescale 1ns/10ps

module tb_hps_model #(
	parameter logic [31:0] UART_BASE_ADDR = 32'hFFC02000,
	parameter logic [31:0] VERSION_ADDR   = 32'hFFC020F8
) (
	input  logic                        FPGA_CLK1_50,
	input  logic                        master_reset,
	input  logic                        bus_req,
	input  uart_greeter_pkg::bus_cmd_t  bus_cmd,
	output logic                        bus_ack,
	output uart_greeter_pkg::bus_word_t bus_rdata,
	output uart_greeter_pkg::bus_word_t version_word,
	output logic                        thr_valid,
	output logic [7:0]                  thr_byte,
	output int                          version_reads,
	output int                          model_errors
);

	localparam logic [31:0] lsr_addr = UART_BASE_ADDR + uart_greeter_pkg::uart_lsr_offset;
	localparam logic [31:0] thr_addr = UART_BASE_ADDR + uart_greeter_pkg::uart_thr_offset;

	logic [31:0]                lfsr;
	logic [31:0]                rnd;
	logic [1:0]                 wait_cnt;
	logic                       thre_seen;
	logic                       req_q;
	uart_greeter_pkg::bus_cmd_t cmd_q;

	// Right-shift Galois form, maximal length taps
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic flag_error(input string msg);
		$display("%s", msg);
		model_errors++;
	endtask

	// Bus inputs of the DUT known from time zero
	initial begin
		bus_ack      = 1'b0;
		bus_rdata    = '0;
		model_errors = 0;
	end

	always @(posedge FPGA_CLK1_50) begin
		thr_valid <= 1'b0;
		if (master_reset) begin
			// Reseeded on every reset cycle, so the word stays fixed
			lfsr = 32'h0f0f6c69;
			take_bits(32, rnd);
			version_word  <= rnd;
			bus_ack       <= 1'b0;
			wait_cnt      <= 2'd0;
			thre_seen     <= 1'b0;
			version_reads <= 0;
			req_q         <= 1'b0;
		end else begin
			// ------------------------------
			// Handshake checks
			// ------------------------------
			// Command frozen while requested
			if (req_q && bus_req) begin
				assert (bus_cmd == cmd_q) else
					flag_error($sformatf("FAILED bus_cmd got %h expected %h", bus_cmd, cmd_q));
			end
			// Drop only after ack, rise only with ack low
			if (req_q && !bus_req) begin
				assert (bus_ack) else flag_error("bus_req fell before bus_ack rose");
			end
			if (!req_q && bus_req) begin
				assert (!bus_ack) else flag_error("bus_req rose while bus_ack was still high");
			end
			req_q <= bus_req;
			cmd_q <= bus_cmd;

			// ------------------------------
			// Register responder
			// ------------------------------
			// Random wait of up to three cycles before the ack
			if (bus_req && !bus_ack && wait_cnt != 2'd0) begin
				wait_cnt <= wait_cnt - 2'd1;
			end else if (bus_req && !bus_ack) begin
				bus_ack   <= 1'b1;
				bus_rdata <= '0;
				if (bus_cmd.write && bus_cmd.addr == thr_addr) begin
					// THR write needs a THRE read since the last one
					assert (thre_seen) else
						flag_error("THR written without a THRE status read before it");
					thre_seen <= 1'b0;
					thr_valid <= 1'b1;
					thr_byte  <= bus_cmd.wdata[7:0];
				end else if (!bus_cmd.write && bus_cmd.addr == lsr_addr) begin
					// Transmitter busy on about one read in four
					take_bits(2, rnd);
					if (rnd[1:0] != 2'b00) begin
						bus_rdata <= 32'h0000_0060;   // THRE and TEMT
						thre_seen <= 1'b1;
					end
				end else if (!bus_cmd.write && bus_cmd.addr == VERSION_ADDR) begin
					bus_rdata     <= version_word;
					version_reads <= version_reads + 1;
				end else begin
					flag_error($sformatf("unexpected bus access to address %h", bus_cmd.addr));
				end
			end else if (bus_ack && !bus_req) begin
				// Ack low, next latency drawn here
				bus_ack <= 1'b0;
				take_bits(2, rnd);
				wait_cnt <= rnd[1:0];
			end
		end
	end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;

	localparam int          div          = 16;
	localparam logic [31:0] version_addr = 32'hFFC020F8;

	logic                        FPGA_CLK1_50;
	logic                        master_reset;
	logic [1:0]                  KEY;
	logic                        bus_ack;
	uart_greeter_pkg::bus_word_t bus_rdata;
	logic [7:0]                  LED;
	logic                        bus_req;
	uart_greeter_pkg::bus_cmd_t  bus_cmd;
	uart_greeter_pkg::bus_word_t version_word;
	logic                        thr_valid;
	logic [7:0]                  thr_byte;
	int                          version_reads;
	int                          model_errors;
	logic [7:0]                  rx_bytes[$];
	string                       exp_msg;
	int                          errors       = 0;
	int                          beat_errors  = 0;
	int                          beat_cyc     = 0;
	int                          tests_run    = 0;
	int                          tests_failed = 0;
	int                          test_mark;
	int                          n;

	uart_greeter #(
		.VERSION_ADDR    (version_addr),
		.DEBOUNCE_DIV    (div),
		.HEARTBEAT_WIDTH (6)
	) UUT (.*);

	// UART register model on the external bus
	tb_hps_model #(.VERSION_ADDR (version_addr)) u_model (.*);

	initial begin
		FPGA_CLK1_50 = 1'b0;
		forever #4 FPGA_CLK1_50 = ~FPGA_CLK1_50;
	end

	// Byte capture and heartbeat check counted from reset release
	always @(posedge FPGA_CLK1_50) begin
		if (thr_valid) begin
			rx_bytes.push_back(thr_byte);
		end
		if (!master_reset) begin
			assert (LED[7] == beat_cyc[5]) else begin
				$display("FAILED LED[7] got %h expected %h", LED[7], beat_cyc[5]);
				beat_errors++;
			end
			beat_cyc++;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got == want) else begin
			$display("FAILED %s got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int fails);
		tests_run++;
		if (fails == 0) begin
			$display("test %-12s ok", name);
		end else begin
			tests_failed++;
			$display("test %-12s failed with %0d error(s)", name, fails);
		end
	endtask

	// Key low for a number of cycles from this edge on
	task automatic hold_key(input int idx, input int cycles);
		KEY[idx] <= 1'b0;
		repeat (cycles) @(posedge FPGA_CLK1_50);
		KEY[idx] <= 1'b1;
	endtask

	task automatic wait_led(input int idx, input logic level, input int limit);
		int cnt;
		cnt = 0;
		while (LED[idx] !== level && cnt < limit) begin
			@(posedge FPGA_CLK1_50);
			cnt++;
		end
		assert (LED[idx] === level) else begin
			$display("LED[%0d] did not reach %0d within %0d cycles", idx, level, limit);
			errors++;
		end
	endtask

	// LED and bus request both stay low over the window
	task automatic watch_quiet(input int idx, input int cycles);
		repeat (cycles) begin
			@(posedge FPGA_CLK1_50);
			check_value($sformatf("LED[%0d]", idx), LED[idx], 0);
			check_value("bus_req", bus_req, 0);
		end
	endtask

	initial begin
		master_reset = 1'b1;
		KEY          = 2'b11;
		repeat (2) @(posedge FPGA_CLK1_50);
		master_reset <= 0;

		test_mark = errors;
		@(posedge FPGA_CLK1_50);
		check_value("bus_req", bus_req, 0);
		check_value("LED", LED, 0);
		report_test("reset", errors - test_mark);

		// Short pulses filtered on both keys and a long hold on KEY[1] shown
		test_mark = errors;
		for (int k = 1; k >= 0; k--) begin
			// Second pulse starts one cycle earlier in the sample period
			repeat (2) begin
				hold_key(k, div - 1);
				watch_quiet(k, 3 * div);
			end
		end
		fork
			hold_key(1, 2 * div);
			wait_led(1, 1'b1, 3 * div);
		join
		wait_led(1, 1'b0, 3 * div);
		report_test("debounce", errors - test_mark);

		// Press and release of KEY[0] starts one message
		test_mark = errors;
		exp_msg = $sformatf("Hello from the FPGA side\015\0120x%08h: %08h\015\012",
			version_addr, version_word);
		fork
			hold_key(0, 2 * div);
			wait_led(0, 1'b1, 3 * div);
		join
		n = 0;
		while (rx_bytes.size() < exp_msg.len() && n < 40000) begin
			@(posedge FPGA_CLK1_50);
			n++;
		end
		assert (rx_bytes.size() >= exp_msg.len()) else begin
			$display("timed out waiting for the message bytes");
			errors++;
		end
		// Room for any stray byte after the last one
		repeat (8 * div) @(posedge FPGA_CLK1_50);
		check_value("byte count", rx_bytes.size(), exp_msg.len());
		for (int i = 0; i < rx_bytes.size() && i < exp_msg.len(); i++) begin
			check_value($sformatf("thr_byte[%0d]", i), rx_bytes[i], exp_msg[i]);
		end
		check_value("version_reads", version_reads, 1);
		report_test("message", errors - test_mark);

		// Model and heartbeat checks ran for the whole simulation
		report_test("bus protocol", model_errors);
		report_test("heartbeat", beat_errors);
		$display("%0d tests, %0d failed, %0d failed checks", tests_run, tests_failed,
			errors + model_errors + beat_errors);
		if (errors + model_errors + beat_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== src/board_panel.sv ====
`timescale 1ns/10ps

module board_panel #(
	parameter int DEBOUNCE_DIV    = 1250000,
	parameter int HEARTBEAT_WIDTH = 26
) (
	input  logic       FPGA_CLK1_50,
	input  logic       master_reset,
	input  logic [1:0] KEY,
	output logic [1:0] keys_down,
	output logic       heartbeat
);

	// Divider needs at least one bit even for a divide of one
	localparam int div_width = (DEBOUNCE_DIV > 1) ? $clog2(DEBOUNCE_DIV) : 1;

	logic [div_width-1:0]       div_cnt;
	logic                       sample_tick;
	logic [1:0]                 sample_new;
	logic [1:0]                 sample_old;
	logic [HEARTBEAT_WIDTH-1:0] beat_cnt;

	// ------------------------------
	// Sample divider
	// ------------------------------

	// One tick every DEBOUNCE_DIV cycles
	assign sample_tick = (div_cnt == div_width'(DEBOUNCE_DIV - 1));

	always_ff @(posedge FPGA_CLK1_50 or posedge master_reset) begin
		if (master_reset) begin
			div_cnt <= '0;
		end else if (sample_tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ------------------------------
	// Key debounce
	// ------------------------------

	// Keys are active low, samples hold pressed as 1
	always_ff @(posedge FPGA_CLK1_50 or posedge master_reset) begin
		if (master_reset) begin
			sample_new <= '0;
			sample_old <= '0;
			keys_down  <= '0;
		end else begin
			if (sample_tick) begin
				sample_old <= sample_new;
				sample_new <= ~KEY;
			end
			// Follow the samples when both agree, otherwise hold
			keys_down <= (sample_new & sample_old) | (keys_down & (sample_new | sample_old));
		end
	end

	// Free-running heartbeat, top bit drives the LED
	always_ff @(posedge FPGA_CLK1_50 or posedge master_reset) begin
		if (master_reset) begin
			beat_cnt <= '0;
		end else begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	assign heartbeat = beat_cnt[HEARTBEAT_WIDTH-1];

endmodule

// ==== src/bus_master.sv ====
`timescale 1ns/10ps

module bus_master (
	input  logic                        FPGA_CLK1_50,
	input  logic                        master_reset,
	input  logic                        acc_start,
	input  uart_greeter_pkg::bus_cmd_t  acc_cmd,
	input  logic                        bus_ack,
	input  uart_greeter_pkg::bus_word_t bus_rdata,
	output logic                        acc_done,
	output uart_greeter_pkg::bus_word_t acc_rdata,
	output logic                        bus_req,
	output uart_greeter_pkg::bus_cmd_t  bus_cmd
);

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_ack_low
	} state_t;

	state_t state;

	// ------------------------------
	// Four-phase handshake
	// ------------------------------

	always_ff @(posedge FPGA_CLK1_50 or posedge master_reset) begin
		if (master_reset) begin
			state    <= st_idle;
			bus_req  <= 1'b0;
			acc_done <= 1'b0;
		end else begin
			acc_done <= 1'b0;
			case (state)
				st_idle: begin
					if (acc_start) begin
						bus_req <= 1'b1;
						state   <= st_req;
					end
				end
				// Hold request until the responder answers
				st_req: begin
					if (bus_ack) begin
						bus_req <= 1'b0;
						state   <= st_ack_low;
					end
				end
				// Done only once ack is seen low again
				default: begin
					if (!bus_ack) begin
						acc_done <= 1'b1;
						state    <= st_idle;
					end
				end
			endcase
		end
	end

	// Command stays put for the whole transfer
	always_ff @(posedge FPGA_CLK1_50) begin
		if (state == st_idle && acc_start) begin
			bus_cmd <= acc_cmd;
		end
		// Read data valid while ack is high
		if (state == st_req && bus_ack) begin
			acc_rdata <= bus_rdata;
		end
	end

endmodule

// ==== src/hps_uart_driver.sv ====
`timescale 1ns/10ps

module hps_uart_driver #(
	parameter logic [31:0] UART_BASE_ADDR = 32'hFFC02000
) (
	input  logic                        FPGA_CLK1_50,
	input  logic                        master_reset,
	input  logic                        uart_req,
	input  uart_greeter_pkg::uart_cmd_t uart_cmd,
	input  logic                        bus_ack,
	input  uart_greeter_pkg::bus_word_t bus_rdata,
	output logic                        uart_ack,
	output uart_greeter_pkg::bus_word_t uart_rdata,
	output logic                        bus_req,
	output uart_greeter_pkg::bus_cmd_t  bus_cmd
);

	localparam logic [31:0] lsr_addr = UART_BASE_ADDR + uart_greeter_pkg::uart_lsr_offset;
	localparam logic [31:0] thr_addr = UART_BASE_ADDR + uart_greeter_pkg::uart_thr_offset;

	typedef enum logic [2:0] {
		st_idle,
		st_poll,
		st_write,
		st_fetch,
		st_ack
	} state_t;

	state_t                      state;
	uart_greeter_pkg::uart_cmd_t cmd_q;
	logic                        acc_start;
	uart_greeter_pkg::bus_cmd_t  acc_cmd;
	logic                        acc_done;
	uart_greeter_pkg::bus_word_t acc_rdata;

	// ------------------------------
	// Command FSM
	// ------------------------------

	// acc_start pulses in the first cycle of each access state
	always_ff @(posedge FPGA_CLK1_50 or posedge master_reset) begin
		if (master_reset) begin
			state     <= st_idle;
			acc_start <= 1'b0;
			uart_ack  <= 1'b0;
		end else begin
			acc_start <= 1'b0;
			case (state)
				st_idle: begin
					if (uart_req) begin
						acc_start <= 1'b1;
						state     <= (uart_cmd.kind == uart_greeter_pkg::send_byte) ?
						             st_poll : st_fetch;
					end
				end
				// Keep reading LSR until THRE is set
				st_poll: begin
					if (acc_done) begin
						acc_start <= 1'b1;
						if (acc_rdata[uart_greeter_pkg::uart_lsr_thre_bit]) begin
							state <= st_write;
						end
					end
				end
				st_write, st_fetch: begin
					if (acc_done) begin
						uart_ack <= 1'b1;
						state    <= st_ack;
					end
				end
				// Close the exchange once the sequencer lets go
				default: begin
					if (!uart_req) begin
						uart_ack <= 1'b0;
						state    <= st_idle;
					end
				end
			endcase
		end
	end

	// Command and fetched word
	always_ff @(posedge FPGA_CLK1_50) begin
		if (state == st_idle && uart_req) begin
			cmd_q <= uart_cmd;
		end
		if (state == st_fetch && acc_done) begin
			uart_rdata <= acc_rdata;
		end
	end

	// Access follows the state it is started in
	always_comb begin
		acc_cmd.write = 1'b0;
		acc_cmd.addr  = lsr_addr;
		acc_cmd.wdata = '0;
		case (state)
			st_write: begin
				acc_cmd.write = 1'b1;
				acc_cmd.addr  = thr_addr;
				acc_cmd.wdata = {24'h000000, cmd_q.data};
			end
			st_fetch: acc_cmd.addr = cmd_q.addr;
			default:  acc_cmd.addr = lsr_addr;
		endcase
	end

	bus_master u_bus_master (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.master_reset (master_reset),
		.acc_start    (acc_start),
		.acc_cmd      (acc_cmd),
		.bus_ack      (bus_ack),
		.bus_rdata    (bus_rdata),
		.acc_done     (acc_done),
		.acc_rdata    (acc_rdata),
		.bus_req      (bus_req),
		.bus_cmd      (bus_cmd)
	);

endmodule

// ==== src/message_sequencer.sv ====
`timescale 1ns/10ps

module message_sequencer #(
	parameter logic [31:0] VERSION_ADDR = 32'hFFC020F8
) (
	input  logic                        FPGA_CLK1_50,
	input  logic                        master_reset,
	input  logic                        start_key,
	input  logic                        uart_ack,
	input  uart_greeter_pkg::bus_word_t uart_rdata,
	output logic                        uart_req,
	output uart_greeter_pkg::uart_cmd_t uart_cmd
);

	localparam logic [7:0] ascii_cr = 8'h0d;
	localparam logic [7:0] ascii_lf = 8'h0a;

	// Greeting, its line end and the address prefix in one string
	localparam int text_len = 38;
	localparam logic [8*text_len-1:0] text_rom = {
		"Hello from the FPGA side", ascii_cr, ascii_lf, "0xffc020f8: "
	};

	typedef enum logic [2:0] {
		st_idle,
		st_release,
		st_text,
		st_fetch,
		st_hex,
		st_tail
	} state_t;

	state_t      state;
	logic [5:0]  char_cnt;
	logic [31:0] version_q;
	logic [3:0]  nibble;
	logic [7:0]  hex_char;

	// ------------------------------
	// Message FSM
	// ------------------------------

	// Counter runs down, highest index is sent first
	always_ff @(posedge FPGA_CLK1_50 or posedge master_reset) begin
		if (master_reset) begin
			state    <= st_idle;
			uart_req <= 1'b0;
			char_cnt <= '0;
		end else begin
			case (state)
				// Wait for press
				st_idle: begin
					if (start_key) begin
						state <= st_release;
					end
				end
				// Wait for release, then start on the greeting
				st_release: begin
					if (!start_key) begin
						state    <= st_text;
						char_cnt <= 6'(text_len - 1);
					end
				end
				// Text, fetch, hex and tail all share the handshake
				default: begin
					if (!uart_req && !uart_ack) begin
						// Previous exchange fully closed
						uart_req <= 1'b1;
					end else if (uart_req && uart_ack) begin
						uart_req <= 1'b0;
						if (char_cnt != '0) begin
							char_cnt <= char_cnt - 1'b1;
						end else begin
							case (state)
								// Single fetch follows the text, counter already at zero
								st_text: state <= st_fetch;
								st_fetch: begin
									state    <= st_hex;
									char_cnt <= 6'(uart_greeter_pkg::hex_digit_count - 1);
								end
								// CR then LF
								st_hex: begin
									state    <= st_tail;
									char_cnt <= 6'd1;
								end
								default: state <= st_idle;
							endcase
						end
					end
				end
			endcase
		end
	end

	// Version word arrives with the fetch ack
	always_ff @(posedge FPGA_CLK1_50) begin
		if (state == st_fetch && uart_req && uart_ack) begin
			version_q <= uart_rdata;
		end
	end

	// ------------------------------
	// Command build
	// ------------------------------

	always_comb begin
		// Current nibble, most significant digit at count 7
		nibble = version_q[4*char_cnt[2:0] +: 4];
		// Lower-case hex, 'a' minus ten is 0x57
		hex_char = (nibble < 4'd10) ? (8'h30 + nibble) : (8'h57 + nibble);

		uart_cmd.kind = uart_greeter_pkg::send_byte;
		// Address only matters for the fetch
		uart_cmd.addr = VERSION_ADDR;
		uart_cmd.data = 8'h00;
		case (state)
			st_text:  uart_cmd.data = text_rom[8*char_cnt +: 8];
			st_fetch: uart_cmd.kind = uart_greeter_pkg::fetch_word;
			st_hex:   uart_cmd.data = hex_char;
			st_tail:  uart_cmd.data = char_cnt[0] ? ascii_cr : ascii_lf;
			default:  uart_cmd.data = 8'h00;
		endcase
	end

endmodule

// ==== src/uart_greeter.sv ====
`timescale 1ns/10ps

module uart_greeter #(
	parameter logic [31:0] UART_BASE_ADDR  = 32'hFFC02000,
	parameter logic [31:0] VERSION_ADDR    = 32'hFFC020F8,
	parameter int          DEBOUNCE_DIV    = 1250000,
	parameter int          HEARTBEAT_WIDTH = 26
) (
	input  logic                        FPGA_CLK1_50,
	input  logic                        master_reset,
	input  logic [1:0]                  KEY,
	input  logic                        bus_ack,
	input  uart_greeter_pkg::bus_word_t bus_rdata,
	output logic [7:0]                  LED,
	output logic                        bus_req,
	output uart_greeter_pkg::bus_cmd_t  bus_cmd
);

	logic [1:0]                  keys_down;
	logic                        heartbeat;
	logic                        uart_req;
	logic                        uart_ack;
	uart_greeter_pkg::uart_cmd_t uart_cmd;
	uart_greeter_pkg::bus_word_t uart_rdata;

	// Keys and heartbeat
	board_panel #(
		.DEBOUNCE_DIV    (DEBOUNCE_DIV),
		.HEARTBEAT_WIDTH (HEARTBEAT_WIDTH)
	) u_panel (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.master_reset (master_reset),
		.KEY          (KEY),
		.keys_down    (keys_down),
		.heartbeat    (heartbeat)
	);

	// LED 7 blinks, 1 and 0 follow the keys
	assign LED = {heartbeat, 5'b00000, keys_down};

	// KEY[0] starts the message
	message_sequencer #(
		.VERSION_ADDR (VERSION_ADDR)
	) u_sequencer (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.master_reset (master_reset),
		.start_key    (keys_down[0]),
		.uart_ack     (uart_ack),
		.uart_rdata   (uart_rdata),
		.uart_req     (uart_req),
		.uart_cmd     (uart_cmd)
	);

	hps_uart_driver #(
		.UART_BASE_ADDR (UART_BASE_ADDR)
	) u_driver (
		.FPGA_CLK1_50 (FPGA_CLK1_50),
		.master_reset (master_reset),
		.uart_req     (uart_req),
		.uart_cmd     (uart_cmd),
		.bus_ack      (bus_ack),
		.bus_rdata    (bus_rdata),
		.uart_ack     (uart_ack),
		.uart_rdata   (uart_rdata),
		.bus_req      (bus_req),
		.bus_cmd      (bus_cmd)
	);

endmodule

// ==== src/uart_greeter_pkg.sv ====
package uart_greeter_pkg;

	// ------------------------------
	// External bus
	// ------------------------------

	// One data word as carried on the bus
	typedef logic [31:0] bus_word_t;

	// Single bus access
	// Write flag on top, then address, then write data
	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		bus_word_t   wdata;
	} bus_cmd_t;

	// ------------------------------
	// Sequencer to driver commands
	// ------------------------------

	// What the driver is asked to do
	typedef enum logic {
		send_byte  = 1'b0,
		fetch_word = 1'b1
	} uart_cmd_kind_t;

	// Byte is used by send_byte, address by fetch_word
	typedef struct packed {
		uart_cmd_kind_t kind;
		logic [7:0]     data;
		logic [31:0]    addr;
	} uart_cmd_t;

	// 16550 register map, offsets from the UART base
	localparam logic [31:0] uart_thr_offset = 32'h0000_0000;
	localparam logic [31:0] uart_lsr_offset = 32'h0000_0014;

	// Transmit holding register empty flag in LSR
	localparam int uart_lsr_thre_bit = 5;

	// Hex digits printed per 32-bit word
	localparam int hex_digit_count = 8;

endpackage

// ==== verilog.f ====
src/uart_greeter_pkg.sv
src/board_panel.sv
src/bus_master.sv
src/hps_uart_driver.sv
src/message_sequencer.sv
src/uart_greeter.sv
bench/tb_hps_model.sv
bench/tb_top.sv
